/* include/datapath_defs.svh */
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// bus and register width
`define DATA_WIDTH 32

// general registers, also width of regIn and regOut
`define NUM_REGS 16

// ALU opcode width
`define ALU_OP_WIDTH 5

`endif

/* hdl/datapathPkg.sv */
`include "datapath_defs.svh"

package datapathPkg;

  // ALU operations, numbered as in the instruction set
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    opAdd  = 5'b00011,
    opSub  = 5'b00100,
    opAnd  = 5'b00101,
    opOr   = 5'b00110,
    opShr  = 5'b00111,
    opShra = 5'b01000,
    opShl  = 5'b01001,
    opRor  = 5'b01010,
    opRol  = 5'b01011,
    opMul  = 5'b01111,
    opDiv  = 5'b10000,
    opNeg  = 5'b10001,
    opNot  = 5'b10010
  } aluOpT;

  // bus sources, lowest value has highest priority
  typedef enum logic [4:0] {
    srcR0, srcR1, srcR2, srcR3,
    srcR4, srcR5, srcR6, srcR7,
    srcR8, srcR9, srcR10, srcR11,
    srcR12, srcR13, srcR14, srcR15,
    srcHi,     // 16
    srcLo,
    srcZHigh,
    srcZLow,
    srcPc,     // from outside the datapath
    srcMdr,
    srcInPort,
    srcC       // sign extended constant
  } busSrcT;

endpackage

/* hdl/busSrcIf.sv */
`include "datapath_defs.svh"

// values each storage block offers to the shared bus
interface busSrcIf;

  logic [`DATA_WIDTH-1:0] regVal [`NUM_REGS]; // R0 already masked
  logic [`DATA_WIDTH-1:0] hiVal;
  logic [`DATA_WIDTH-1:0] loVal;
  logic [`DATA_WIDTH-1:0] inPortVal;
  logic [`DATA_WIDTH-1:0] zHighVal;
  logic [`DATA_WIDTH-1:0] zLowVal;

  modport producerRegs (
    output regVal
  );

  modport producerAux (
    output hiVal, loVal, inPortVal
  );

  modport producerAlu (
    output zHighVal, zLowVal
  );

  modport selector (
    input regVal, hiVal, loVal, inPortVal, zHighVal, zLowVal
  );

endinterface

/* hdl/regFile.sv */
`include "datapath_defs.svh"

module regFile (
  input  logic                     clock,
  input  logic                     rstN,
  input  logic [`DATA_WIDTH-1:0]   busData,
  input  logic [`NUM_REGS-1:0]     regIn,   // one load enable per register
  input  logic                     baOut,   // base address use of R0
  input  logic                     jalR15,  // jump and link
  busSrcIf.producerRegs            src
);

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];
  logic [`NUM_REGS-1:0]   loadEn;

  always_comb begin
    loadEn = regIn;
    // link address goes to R15 without its regIn bit
    loadEn[`NUM_REGS-1] = regIn[`NUM_REGS-1] | jalR15;
  end

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        if (loadEn[i]) begin
          regs[i] <= busData;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `NUM_REGS; i++) begin
      src.regVal[i] = regs[i];
    end
    if (baOut) begin
      src.regVal[0] = '0; // R0 reads zero as a base
    end
  end

  // a link load and an ordinary load of R15 never coincide
  aJalNoRegIn: assert property (@(posedge clock) disable iff (!rstN)
    jalR15 |-> !regIn[`NUM_REGS-1])
    else $error("regFile: jalR15 and regIn[15] high together");

endmodule

/* hdl/auxRegs.sv */
`include "datapath_defs.svh"

module auxRegs (
  input  logic                    clock,
  input  logic                    rstN,
  input  logic [`DATA_WIDTH-1:0]  busData,
  input  logic                    hiIn,
  input  logic                    loIn,
  input  logic                    inPortEn,
  input  logic                    outPortEn,
  input  logic [`DATA_WIDTH-1:0]  inPortData,   // from the pins
  output logic [`DATA_WIDTH-1:0]  outPortData,  // to the pins
  busSrcIf.producerAux            src
);

  logic [`DATA_WIDTH-1:0] hiReg;
  logic [`DATA_WIDTH-1:0] loReg;
  logic [`DATA_WIDTH-1:0] inPortReg;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      hiReg       <= '0;
      loReg       <= '0;
      inPortReg   <= '0;
      outPortData <= '0;
    end else begin
      if (hiIn) hiReg <= busData;
      if (loIn) loReg <= busData;
      if (inPortEn) inPortReg <= inPortData; // not from the bus
      if (outPortEn) outPortData <= busData;
    end
  end

  assign src.hiVal     = hiReg;
  assign src.loVal     = loReg;
  assign src.inPortVal = inPortReg;

  // HI and LO are moved one at a time over the single bus, and the
  // port strobe comes from the controller and must stay defined
  aHiLoPort: assert property (@(posedge clock) disable iff (!rstN)
    !(hiIn && loIn) && !$isunknown(inPortEn))
    else $error("auxRegs: hiIn with loIn, or inPortEn unknown");

endmodule

/* hdl/aluUnit.sv */
`include "datapath_defs.svh"

module aluUnit (
  input  logic                    clock,
  input  logic                    rstN,
  input  logic [`DATA_WIDTH-1:0]  busData,  // B operand and Y source
  input  logic                    yIn,
  input  logic                    zIn,
  input  logic                    incPc,    // overrides aluOp
  input  datapathPkg::aluOpT      aluOp,
  busSrcIf.producerAlu            src
);

  localparam int W   = `DATA_WIDTH;
  localparam int ShW = $clog2(`DATA_WIDTH);

  logic [W-1:0]          yReg;
  logic [W-1:0]          zHighReg;
  logic [W-1:0]          zLowReg;
  logic [2*W-1:0]        aluResult;
  logic [ShW-1:0]        shAmt;
  logic [2*W-1:0]        dblA;       // A twice, for rotates
  logic [2*W-1:0]        rorWide;
  logic [2*W-1:0]        rolWide;
  logic [W-1:0]          diff;
  logic [W-1:0]          negB;
  logic signed [2*W-1:0] product;
  logic signed [W-1:0]   quot;
  logic signed [W-1:0]   rem;

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      yReg     <= '0;
      zHighReg <= '0;
      zLowReg  <= '0;
    end else begin
      if (yIn) yReg <= busData;
      if (zIn) begin
        zHighReg <= aluResult[2*W-1:W];
        zLowReg  <= aluResult[W-1:0];
      end
    end
  end

  assign shAmt   = busData[ShW-1:0];
  assign dblA    = {yReg, yReg};
  assign rorWide = dblA >> shAmt;
  assign rolWide = dblA << shAmt;
  assign diff    = yReg - busData;
  assign negB    = -busData;        // neg and not act on the bus operand
  assign product = $signed(yReg) * $signed(busData);
  assign quot    = $signed(yReg) / $signed(busData);
  assign rem     = $signed(yReg) % $signed(busData);

  always_comb begin
    aluResult = '0;
    if (incPc) begin
      aluResult[W-1:0] = busData + 1'b1; // wraps at all ones
    end else begin
      case (aluOp)
        datapathPkg::opAdd:  aluResult[W-1:0] = yReg + busData;
        datapathPkg::opSub:  aluResult = {{W{diff[W-1]}}, diff};
        datapathPkg::opAnd:  aluResult[W-1:0] = yReg & busData;
        datapathPkg::opOr:   aluResult[W-1:0] = yReg | busData;
        datapathPkg::opShr:  aluResult[W-1:0] = yReg >> shAmt;
        datapathPkg::opShra: aluResult[W-1:0] = $signed(yReg) >>> shAmt;
        datapathPkg::opShl:  aluResult[W-1:0] = yReg << shAmt;
        datapathPkg::opRor:  aluResult[W-1:0] = rorWide[W-1:0];
        datapathPkg::opRol:  aluResult[W-1:0] = rolWide[2*W-1:W];
        datapathPkg::opMul:  aluResult = product;
        datapathPkg::opDiv: begin
          if (busData == '0) begin
            aluResult = {yReg, {W{1'b1}}}; // remainder A, quotient all ones
          end else begin
            aluResult = {rem, quot};
          end
        end
        datapathPkg::opNeg:  aluResult = {{W{negB[W-1]}}, negB};
        datapathPkg::opNot:  aluResult[W-1:0] = ~busData;
        default:             aluResult = '0;
      endcase
    end
  end

  assign src.zHighVal = zHighReg;
  assign src.zLowVal  = zLowReg;

  // a Z load must come from a real operation unless incPc overrides
  aOpDefined: assert property (@(posedge clock) disable iff (!rstN)
    (zIn && !incPc) |-> aluOp inside {
      datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opAnd,
      datapathPkg::opOr, datapathPkg::opShr, datapathPkg::opShra,
      datapathPkg::opShl, datapathPkg::opRor, datapathPkg::opRol,
      datapathPkg::opMul, datapathPkg::opDiv, datapathPkg::opNeg,
      datapathPkg::opNot})
    else $error("aluUnit: undefined aluOp %0h with zIn", aluOp);

endmodule

/* hdl/busSelect.sv */
`include "datapath_defs.svh"

module busSelect (
  input  logic                    clock,
  input  logic                    rstN,
  input  logic [`NUM_REGS-1:0]    regOut,
  input  logic                    hiOut,
  input  logic                    loOut,
  input  logic                    zHighOut,
  input  logic                    zLowOut,
  input  logic                    pcOut,
  input  logic                    mdrOut,
  input  logic                    inPortOut,
  input  logic                    cOut,
  input  logic [`DATA_WIDTH-1:0]  busInPc,
  input  logic [`DATA_WIDTH-1:0]  busInMdr,
  input  logic [`DATA_WIDTH-1:0]  cSignExtended,
  output logic [`DATA_WIDTH-1:0]  busData,
  busSrcIf.selector               src
);

  localparam int NumSrc = int'(datapathPkg::srcC) + 1;

  logic [NumSrc-1:0]   outEn;
  datapathPkg::busSrcT selIdx;
  logic                selValid;

  // bit position equals the busSrcT index
  assign outEn = {cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut,
                  loOut, hiOut, regOut};

  // priority encoder, lowest index wins
  always_comb begin
    selIdx   = datapathPkg::srcR0;
    selValid = 1'b0;
    for (int i = NumSrc - 1; i >= 0; i--) begin
      if (outEn[i]) begin
        selIdx   = datapathPkg::busSrcT'(i);
        selValid = 1'b1;
      end
    end
  end

  always_comb begin
    busData = '0; // idle bus reads zero
    if (selValid) begin
      case (selIdx)
        datapathPkg::srcHi:     busData = src.hiVal;
        datapathPkg::srcLo:     busData = src.loVal;
        datapathPkg::srcZHigh:  busData = src.zHighVal;
        datapathPkg::srcZLow:   busData = src.zLowVal;
        datapathPkg::srcPc:     busData = busInPc;
        datapathPkg::srcMdr:    busData = busInMdr;
        datapathPkg::srcInPort: busData = src.inPortVal;
        datapathPkg::srcC:      busData = cSignExtended;
        default:                busData = src.regVal[selIdx[3:0]]; // R0..R15
      endcase
    end
  end

  aOneDriver: assert property (@(posedge clock) disable iff (!rstN)
    $onehot0(outEn))
    else $error("busSelect: more than one bus driver, outEn %h", outEn);

endmodule

/* hdl/datapath.sv */
`include "datapath_defs.svh"

module datapath (
  input  logic                       clock,
  input  logic                       rstN,
  // external data
  input  logic [`DATA_WIDTH-1:0]     inPortData,
  input  logic [`DATA_WIDTH-1:0]     busInPc,        // PC value
  input  logic [`DATA_WIDTH-1:0]     busInMdr,       // memory data
  input  logic [`DATA_WIDTH-1:0]     cSignExtended,  // immediate
  // general registers
  input  logic [`NUM_REGS-1:0]       regIn,
  input  logic [`NUM_REGS-1:0]       regOut,
  // ALU and result registers
  input  logic                       yIn,
  input  logic                       hiIn,
  input  logic                       hiOut,
  input  logic                       loIn,
  input  logic                       loOut,
  input  logic                       zIn,
  input  logic                       zHighOut,
  input  logic                       zLowOut,
  // external sources and ports
  input  logic                       pcOut,
  input  logic                       incPc,
  input  logic                       mdrOut,
  input  logic                       inPortOut,
  input  logic                       inPortEn,
  input  logic                       outPortEn,
  input  logic                       cOut,
  input  logic                       baOut,
  input  logic                       jalR15,
  input  logic [`ALU_OP_WIDTH-1:0]   aluOp,
  output logic [`DATA_WIDTH-1:0]     busData,
  output logic [`DATA_WIDTH-1:0]     outPortData
);

  busSrcIf srcBus ();

  regFile uRegFile (
    .clock   (clock),
    .rstN    (rstN),
    .busData (busData),
    .regIn   (regIn),
    .baOut   (baOut),
    .jalR15  (jalR15),
    .src     (srcBus.producerRegs)
  );

  auxRegs uAuxRegs (
    .clock       (clock),
    .rstN        (rstN),
    .busData     (busData),
    .hiIn        (hiIn),
    .loIn        (loIn),
    .inPortEn    (inPortEn),
    .outPortEn   (outPortEn),
    .inPortData  (inPortData),
    .outPortData (outPortData),
    .src         (srcBus.producerAux)
  );

  aluUnit uAluUnit (
    .clock   (clock),
    .rstN    (rstN),
    .busData (busData),
    .yIn     (yIn),
    .zIn     (zIn),
    .incPc   (incPc),
    .aluOp   (datapathPkg::aluOpT'(aluOp)), // raw opcode from controller
    .src     (srcBus.producerAlu)
  );

  busSelect uBusSelect (
    .clock         (clock),
    .rstN          (rstN),
    .regOut        (regOut),
    .hiOut         (hiOut),
    .loOut         (loOut),
    .zHighOut      (zHighOut),
    .zLowOut       (zLowOut),
    .pcOut         (pcOut),
    .mdrOut        (mdrOut),
    .inPortOut     (inPortOut),
    .cOut          (cOut),
    .busInPc       (busInPc),
    .busInMdr      (busInMdr),
    .cSignExtended (cSignExtended),
    .busData       (busData),
    .src           (srcBus.selector)
  );

endmodule

/* tests/tbDatapath.sv */
`include "datapath_defs.svh"

module tbDatapath;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int W = `DATA_WIDTH;
  // reset, then tests 1 to 6, ALU sequences take four cycles each
  localparam int TestCycles = 10 + 25 + 35 + 49 * 4 + 9 * 4 + 4 + 6 + 8;
  localparam int CycleLimit = 2 * TestCycles;
  localparam logic [4:0] AluOps [11] = '{
    datapathPkg::opAdd, datapathPkg::opSub, datapathPkg::opAnd, datapathPkg::opOr,
    datapathPkg::opShr, datapathPkg::opShra, datapathPkg::opShl, datapathPkg::opRor,
    datapathPkg::opRol, datapathPkg::opNeg, datapathPkg::opNot};

  logic clock = 1'b0;
  logic rstN;
  logic [W-1:0] inPortData, busInPc, busInMdr, cSignExtended;
  logic [`NUM_REGS-1:0] regIn, regOut;
  logic yIn, hiIn, hiOut, loIn, loOut, zIn, zHighOut, zLowOut;
  logic pcOut, incPc, mdrOut, inPortOut, inPortEn, outPortEn, cOut, baOut, jalR15;
  logic [`ALU_OP_WIDTH-1:0] aluOp;
  logic [W-1:0] busData, outPortData;

  string chkName;
  logic [W-1:0] chkExp, chkAct;
  int checks = 0;
  int errors = 0;
  int errorsAtStart = 0;
  int cycleCount = 0;
  integer seed = 32'h1156_04b2;
  event sampleReady;

  datapath DUT (.*);

  always #5 clock = ~clock;

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount > CycleLimit) begin
      $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  always @(sampleReady) begin
    checks++;
    if (chkAct !== chkExp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", chkName, chkExp, chkAct);
    end
  end

  // expected 64-bit ALU result, A from Y and B from the bus
  function automatic logic [2*W-1:0] aluRef(logic [4:0] op, logic [W-1:0] a,
                                            logic [W-1:0] b);
    logic [W-1:0] lo;
    logic signed [2*W-1:0] sa;
    logic signed [2*W-1:0] sb;
    int sh;
    sh = int'(b[4:0]);
    sa = $signed(a);
    sb = $signed(b);
    case (op)
      datapathPkg::opAdd: return {{W{1'b0}}, a + b};
      datapathPkg::opSub: begin
        lo = a - b;
        return {{W{lo[W-1]}}, lo}; // sign filled high word
      end
      datapathPkg::opAnd: return {{W{1'b0}}, a & b};
      datapathPkg::opOr: return {{W{1'b0}}, a | b};
      datapathPkg::opShr: return {{W{1'b0}}, a >> sh};
      datapathPkg::opShra: return {{W{1'b0}}, $signed(a) >>> sh};
      datapathPkg::opShl: return {{W{1'b0}}, a << sh};
      datapathPkg::opRor: begin
        lo = (a >> sh) | (a << (W - sh));
        return {{W{1'b0}}, lo};
      end
      datapathPkg::opRol: begin
        lo = (a << sh) | (a >> (W - sh));
        return {{W{1'b0}}, lo};
      end
      datapathPkg::opMul: return sa * sb;
      datapathPkg::opDiv: begin
        if (b == '0) return {a, {W{1'b1}}};
        return {$signed(a) % $signed(b), $signed(a) / $signed(b)};
      end
      datapathPkg::opNeg: begin
        lo = -b;
        return {{W{lo[W-1]}}, lo};
      end
      datapathPkg::opNot: return {{W{1'b0}}, ~b};
      default: return '0;
    endcase
  endfunction

  task automatic clearStrobes();
    regIn = '0;
    regOut = '0;
    {yIn, hiIn, hiOut, loIn, loOut, zIn, zHighOut, zLowOut} = '0;
    {pcOut, incPc, mdrOut, inPortOut, inPortEn, outPortEn, cOut, baOut, jalR15} = '0;
  endtask

  task automatic nextCycle();
    @(posedge clock);
    #1;
    clearStrobes();
  endtask

  // constant onto the bus, caller adds the load enable
  task automatic busConst(logic [W-1:0] value);
    nextCycle();
    cOut = 1'b1;
    cSignExtended = value;
  endtask

  task automatic selectSrc(int idx);
    nextCycle();
    case (idx)
      datapathPkg::srcHi: hiOut = 1'b1;
      datapathPkg::srcLo: loOut = 1'b1;
      datapathPkg::srcZHigh: zHighOut = 1'b1;
      datapathPkg::srcZLow: zLowOut = 1'b1;
      datapathPkg::srcPc: pcOut = 1'b1;
      datapathPkg::srcMdr: mdrOut = 1'b1;
      datapathPkg::srcInPort: inPortOut = 1'b1;
      datapathPkg::srcC: cOut = 1'b1;
      default: regOut[idx[3:0]] = 1'b1;
    endcase
  endtask

  task automatic sampleBus(string name, logic [W-1:0] exp, bit fromPort = 1'b0);
    int checksBefore;
    @(negedge clock); // mid cycle, bus settled
    chkName = fromPort ? name : $sformatf("busData %s", name);
    chkExp = exp;
    chkAct = fromPort ? outPortData : busData;
    checksBefore = checks;
    -> sampleReady;
    wait (checks == checksBefore + 1); // compare done before moving on
  endtask

  task automatic runAlu(logic [4:0] op, logic [W-1:0] a, logic [W-1:0] b);
    logic [2*W-1:0] exp;
    exp = aluRef(op, a, b);
    busConst(a);
    yIn = 1'b1;
    busConst(b);
    zIn = 1'b1;
    aluOp = op;
    selectSrc(datapathPkg::srcZLow);
    sampleBus($sformatf("zLow op %0h", op), exp[W-1:0]);
    selectSrc(datapathPkg::srcZHigh);
    sampleBus($sformatf("zHigh op %0h", op), exp[2*W-1:W]);
  endtask

  task automatic finishTest(string name);
    $display("test %s done, %0d errors", name, errors - errorsAtStart);
    errorsAtStart = errors;
  endtask

  initial begin
    logic [W-1:0] vals [`NUM_REGS];
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [2*W-1:0] prod;
    clearStrobes();
    {inPortData, busInPc, busInMdr, cSignExtended} = '0;
    aluOp = datapathPkg::opAdd;
    rstN = 1'b0;
    repeat (10) @(posedge clock);
    #1 rstN = 1'b1;

    for (int i = 0; i <= int'(datapathPkg::srcInPort); i++) begin
      selectSrc(i);
      sampleBus($sformatf("src %0d", i), '0);
    end
    sampleBus("outPortData", '0, 1'b1);
    finishTest("reset");

    for (int i = 0; i < `NUM_REGS; i++) begin
      vals[i] = $random(seed);
      busConst(vals[i]);
      regIn[i] = 1'b1;
    end
    for (int i = 0; i < `NUM_REGS; i++) begin
      selectSrc(i);
      sampleBus($sformatf("R%0d", i), vals[i]);
    end
    selectSrc(datapathPkg::srcR0);
    baOut = 1'b1;
    sampleBus("R0 baOut", '0);
    a = $random(seed);
    busConst(a);
    jalR15 = 1'b1; // regIn stays clear
    selectSrc(datapathPkg::srcR15);
    sampleBus("R15 jal", a);
    finishTest("register file");

    foreach (AluOps[k]) begin
      repeat (4) runAlu(AluOps[k], $random(seed), $random(seed));
    end
    a = $random(seed);
    runAlu(datapathPkg::opShr, a, 32'h0);
    runAlu(datapathPkg::opShl, a, 32'h20); // low five bits zero
    runAlu(datapathPkg::opRor, a, 32'd31);
    runAlu(datapathPkg::opRol, a, 32'd31);
    runAlu(datapathPkg::opShra, 32'h8000_0000, 32'd31);
    finishTest("alu operations");

    repeat (2) runAlu(datapathPkg::opMul, $random(seed), $random(seed));
    runAlu(datapathPkg::opMul, -32'sd5, 32'sd7);
    repeat (2) runAlu(datapathPkg::opDiv, $random(seed), $random(seed));
    runAlu(datapathPkg::opDiv, 32'sd100, -32'sd7); // negative divisor
    runAlu(datapathPkg::opDiv, -32'sd100, 32'sd7);
    runAlu(datapathPkg::opDiv, $random(seed), 32'h0);
    a = $random(seed);
    b = $random(seed);
    prod = aluRef(datapathPkg::opMul, a, b);
    runAlu(datapathPkg::opMul, a, b);
    selectSrc(datapathPkg::srcZHigh);
    hiIn = 1'b1;
    selectSrc(datapathPkg::srcZLow);
    loIn = 1'b1;
    selectSrc(datapathPkg::srcHi);
    sampleBus("HI", prod[2*W-1:W]);
    selectSrc(datapathPkg::srcLo);
    sampleBus("LO", prod[W-1:0]);
    finishTest("multiply and divide");

    for (int k = 0; k < 3; k++) begin
      a = (k == 0) ? $random(seed) : ((k == 1) ? 32'hFFFF_FFFF : 32'h0);
      selectSrc(datapathPkg::srcPc);
      busInPc = a;
      incPc = 1'b1;
      zIn = 1'b1;
      aluOp = 5'($random(seed)); // ignored under incPc
      selectSrc(datapathPkg::srcZLow);
      sampleBus("zLow incPc", a + 32'h1);
    end
    finishTest("increment");

    a = $random(seed);
    nextCycle();
    inPortData = a;
    inPortEn = 1'b1;
    selectSrc(datapathPkg::srcInPort);
    sampleBus("inPort", a);
    b = $random(seed);
    busConst(b);
    outPortEn = 1'b1;
    nextCycle();
    sampleBus("outPortData", b, 1'b1);
    a = $random(seed);
    selectSrc(datapathPkg::srcMdr);
    busInMdr = a;
    sampleBus("busInMdr", a);
    b = $random(seed);
    selectSrc(datapathPkg::srcC);
    cSignExtended = b;
    sampleBus("cSignExtended", b);
    finishTest("ports and bus sources");

    nextCycle();
    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+include
hdl/datapathPkg.sv
hdl/busSrcIf.sv
hdl/regFile.sv
hdl/auxRegs.sv
hdl/aluUnit.sv
hdl/busSelect.sv
hdl/datapath.sv
tests/tbDatapath.sv

/* Makefile */
TOOL       = verilator
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall -Wno-fatal
TOP        = tbDatapath
FILELIST   = compile.f
OBJDIR     = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
